// ==== verification/datapath_golden.txt ====
# name, strobes aluEn aluWe cFlag irWe lrEn lrWe memEn pcEn pcWe regWe (binary),
# immSel op1Sel op2Sel rwSel rs1Sel pcSel lrSel wdSel aluOr, dataIn, sysBus (---- skip), ir, NZCV
idle       0000000000 0 0 0 0 0 0 0 0 0 0000 ---- 0000 4
pcReset    0000000100 0 0 0 0 0 0 0 0 0 0000 0000 0000 4
fetchMov   0001001000 0 0 0 0 0 0 0 0 0 7b00 7b00 0000 4
writeReg   0000001001 0 0 0 1 0 0 0 1 0 1234 1234 7b00 4
movLatch   0100000000 0 0 2 0 0 0 0 0 0 0000 ---- 7b00 0
aluDrive   1000000000 0 0 2 0 0 0 0 0 0 0000 1234 7b00 0
fetchAddi  0001001000 0 0 0 0 0 0 0 0 0 0b1f 0b1f 7b00 0
addiShort  0100000000 0 0 1 0 0 0 0 0 0 0000 ---- 0b1f 2
addiLong   1000000000 1 0 1 0 0 0 0 0 0 0000 1233 0b1f 0
write7fff  0000001001 0 0 0 1 0 0 0 1 0 7fff 7fff 0b1f 0
incOvf     0000000000 0 0 2 0 0 0 0 0 1 0000 ---- 0b1f 9
fetchSubi  0001001000 0 0 0 0 0 0 0 0 0 2b05 2b05 0b1f 0
write5     0000001001 0 0 0 1 0 0 0 1 0 0005 0005 2b05 2
subiZero   0000000000 0 0 1 0 0 0 0 0 0 0000 ---- 2b05 6
fetchAdci  0001001000 0 0 0 0 0 0 0 0 0 1b02 1b02 2b05 2
adciC0     0100000000 0 0 1 0 0 0 0 0 0 0000 ---- 1b02 0
adciC1     1110000000 0 0 1 0 0 0 0 0 0 0000 0007 1b02 0
adciDrive  1000000000 0 0 0 0 0 0 0 0 0 0000 0008 1b02 0
fetchSuci  0001001000 0 0 0 0 0 0 0 0 0 3b02 3b02 1b02 0
suciC1     0110000000 0 0 1 0 0 0 0 0 0 0000 ---- 3b02 2
suciC0     1100000000 0 0 1 0 0 0 0 0 0 0000 0003 3b02 2
suciDrive  1000000000 0 0 0 0 0 0 0 0 0 0000 0002 3b02 2
pcInc      0000000010 0 0 0 0 0 3 0 0 0 0000 ---- 3b02 2
pcIncRead  0000000110 0 0 0 0 0 3 0 0 0 0000 0001 3b02 2
pcRel      0000000110 0 1 1 0 0 1 0 0 1 0000 0002 3b02 0
pcRelRead  0000010100 0 0 0 0 0 0 0 0 0 0000 0005 3b02 2
pcInt      0000100010 0 0 0 0 0 4 0 0 0 0000 0006 3b02 2
pcIntRead  0000000110 0 0 0 0 0 0 0 0 0 0000 0010 3b02 2
pcLrRead   0000000100 0 0 0 0 0 0 0 0 0 0000 0006 3b02 2

// ==== flist.f ====
design/opcodes.sv
design/trisreg.sv
design/regBlock.sv
design/aluDecode.sv
design/alu.sv
design/datapath.sv
verification/datapathTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module datapathTb -o datapathSim
./obj_dir/datapathSim > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi
exit 1

// ==== verification/datapathTb.sv ====
// controller model for the datapath; run from the project root so the golden file path resolves
`timescale 1ns/1ps
module datapathTb import opcodes::*; ();

	logic Clock = 1'b0;
	logic rstN;
	logic [15:0] dataIn;
	wire [15:0] sysBus;
	logic aluEn, aluWe, cFlag, irWe, lrEn, lrWe, memEn, pcEn, pcWe, regWe;
	immSelT immSel;
	op1SelT op1Sel;
	op2SelT op2Sel;
	rwSelT rwSel;
	rs1SelT rs1Sel;
	pcSelT pcSel;
	lrSelT lrSel;
	wdSelT wdSel;
	aluOrSelT aluOr;
	logic [3:0] flags;
	instrWordT ir;

	string vectors[$]; // raw golden lines without the column notes
	int cycleCount = 0;
	int cycleLimit = 0;

	// fields of the vector being applied
	string vName, vBus;
	logic [9:0] vStrobes;
	logic vImm, vOp1, vRs1, vLr, vWd;
	logic [1:0] vOp2, vRw, vOr;
	logic [2:0] vPc;
	logic [15:0] vData, vIr, vBusWord;
	logic [3:0] vFlags;
	logic vBusCheck;

	datapath uut (
		.Clock(Clock), .rstN(rstN), .dataIn(dataIn), .sysBus(sysBus),
		.aluEn(aluEn), .aluWe(aluWe), .cFlag(cFlag), .irWe(irWe), .lrEn(lrEn),
		.lrWe(lrWe), .memEn(memEn), .pcEn(pcEn), .pcWe(pcWe), .regWe(regWe),
		.immSel(immSel), .op1Sel(op1Sel), .op2Sel(op2Sel), .rwSel(rwSel),
		.rs1Sel(rs1Sel), .pcSel(pcSel), .lrSel(lrSel), .wdSel(wdSel), .aluOr(aluOr),
		.flags(flags), .ir(ir)
	);

	always #50 Clock = ~Clock; // 100 ns period

	always @(posedge Clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: no result after %0d clock cycles", cycleLimit);
			$display("Simulation finished: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic checkWord(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("ERR %s: sysBus expected %h, actual %h", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "bus mismatch");
		end
	endtask

	task automatic checkIr(input string name, input instrWordT expected,
		input instrWordT actual);
		if (actual !== expected) begin
			$display("ERR %s: ir expected %h, actual %h", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "ir mismatch");
		end
	endtask

	task automatic checkFlags(input string name, input logic [3:0] expected,
		input logic [3:0] actual);
		if (actual !== expected) begin
			$display("ERR %s: flags expected %b, actual %b", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "flags mismatch");
		end
	endtask

	// splits one golden line and returns the number of fields found
	function automatic int parseVector(input string lineStr);
		int count;
		count = $sscanf(lineStr, "%s %b %d %d %d %d %d %d %d %d %d %h %s %h %h",
			vName, vStrobes, vImm, vOp1, vOp2, vRw, vRs1, vPc, vLr, vWd, vOr,
			vData, vBus, vIr, vFlags);
		vBusCheck = (vBus != "----"); // undriven bus is not compared
		if (vBusCheck) begin
			void'($sscanf(vBus, "%h", vBusWord));
		end
		return count;
	endfunction

	task automatic loadVectors();
		int fd;
		int count;
		int lineNo;
		string lineStr;
		lineNo = 0;
		fd = $fopen("verification/datapath_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/datapath_golden.txt");
			$display("Simulation finished: FAIL");
			$fatal(1, "missing golden file");
		end else begin
			while ($fgets(lineStr, fd) != 0) begin
				lineNo++;
				if (lineStr.len() < 2 || lineStr.substr(0, 0) == "#") begin
					continue; // blank or column notes
				end
				count = parseVector(lineStr);
				if (count != 15) begin
					$display("golden line %0d holds %0d fields instead of 15", lineNo, count);
					$display("Simulation finished: FAIL");
					$fatal(1, "short golden line");
				end else begin
					vectors.push_back(lineStr);
				end
			end
			$fclose(fd);
			if (vectors.size() == 0) begin
				$display("golden file holds no test vectors");
				$display("Simulation finished: FAIL");
				$fatal(1, "empty golden file");
			end
		end
	endtask

	task automatic driveVector(input string lineStr);
		void'(parseVector(lineStr));
		{aluEn, aluWe, cFlag, irWe, lrEn, lrWe, memEn, pcEn, pcWe, regWe} <= vStrobes;
		immSel <= immSelT'(vImm);
		op1Sel <= op1SelT'(vOp1);
		op2Sel <= op2SelT'(vOp2);
		rwSel <= rwSelT'(vRw);
		rs1Sel <= rs1SelT'(vRs1);
		pcSel <= pcSelT'(vPc);
		lrSel <= lrSelT'(vLr);
		wdSel <= wdSelT'(vWd);
		aluOr <= aluOrSelT'(vOr);
		dataIn <= vData;
	endtask

	task automatic checkVector();
		if (vBusCheck) begin
			checkWord(vName, vBusWord, sysBus);
		end
		checkIr(vName, vIr, ir);
		checkFlags(vName, vFlags, flags);
	endtask

	initial begin
		rstN <= 1'b0;
		dataIn <= 16'h0000;
		{aluEn, aluWe, cFlag, irWe, lrEn, lrWe, memEn, pcEn, pcWe, regWe} <= 10'b0;
		immSel <= immShort;
		op1Sel <= op1Rd1;
		op2Sel <= op2Rd2;
		rwSel <= rwSeven;
		rs1Sel <= rs1Rd;
		pcSel <= pcLr;
		lrSel <= lrPc;
		wdSel <= wdAlu;
		aluOr <= orNone;
		loadVectors();
		cycleLimit = 2 * vectors.size() + 20;
		repeat (10) @(posedge Clock);
		rstN <= 1'b1;
		foreach (vectors[i]) begin
			@(posedge Clock);
			driveVector(vectors[i]);
			#90; // late in the cycle once all has settled
			checkVector();
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== design/datapath.sv ====
// datapath top; at most one of memEn, pcEn, lrEn, aluEn may be high, nothing here checks it
`timescale 1ns/1ps
module datapath import opcodes::*; (
	input logic Clock,
	input logic rstN,
	input logic [wordW-1:0] dataIn,
	inout wire [wordW-1:0] sysBus,
	input logic aluEn,
	input logic aluWe,
	input logic cFlag,
	input logic irWe,
	input logic lrEn,
	input logic lrWe,
	input logic memEn,
	input logic pcEn,
	input logic pcWe,
	input logic regWe,
	input immSelT immSel,
	input op1SelT op1Sel,
	input op2SelT op2Sel,
	input rwSelT rwSel,
	input rs1SelT rs1Sel,
	input pcSelT pcSel,
	input lrSelT lrSel,
	input wdSelT wdSel,
	input aluOrSelT aluOr,
	output logic [3:0] flags,
	output instrWordT ir
);

	logic [wordW-1:0] pc, lr, aluRes, rd1, rd2, wData;
	logic [wordW-1:0] extended, op1, op2, pcIn, lrIn, pcPlus1;
	logic [2:0] rs1, rw;
	opcodeT aluOpCode;
	aluFunctionT aluOp;
	logic aluCarryIn, aluCarryUse;

	// sign extend from the immediate view of the instruction
	assign extended = (immSel == immShort) ?
		{{11{ir.immForm.imm[4]}}, ir.immForm.imm[4:0]} :
		{{8{ir.immForm.imm[7]}}, ir.immForm.imm};

	assign sysBus = memEn ? dataIn : {wordW{1'bz}}; // memory data onto the bus
	assign wData = (wdSel == wdSys) ? sysBus : aluRes;
	assign pcPlus1 = pc + 16'd1;
	assign lrIn = (lrSel == lrPc) ? pcPlus1 : sysBus;
	assign op1 = (op1Sel == op1Pc) ? pc : rd1;
	assign rs1 = (rs1Sel == rs1Ra) ? ir.regForm.ra : ir.regForm.rd;

	// PC-relative and increment arithmetic overrides the IR
	always_comb begin
		aluOpCode = ir.regForm.opcode;
		aluCarryIn = cFlag;
		case (aluOr)
			orAdd: begin
				aluOpCode = ADCI;
				aluCarryIn = 1'b1;
			end
			orSub: begin
				aluOpCode = SUCI;
				aluCarryIn = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (op2Sel)
			op2Rd2: op2 = rd2;
			op2Imm: op2 = extended;
			default: op2 = '0; // op2Zero
		endcase
		case (rwSel)
			rwRd: rw = ir.regForm.rd;
			rwRa: rw = ir.regForm.ra;
			default: rw = 3'd7; // link register
		endcase
		case (pcSel)
			pcLr: pcIn = lr;
			pcAluOut: pcIn = aluRes;
			pcSysBus: pcIn = sysBus;
			pcInt: pcIn = intVector;
			default: pcIn = pcPlus1;
		endcase
	end

	regBlock regFile (
		.Clock(Clock), .rstN(rstN), .we(regWe),
		.rs1(rs1), .rs2(ir.regForm.rb), .rw(rw),
		.wData(wData), .rd1(rd1), .rd2(rd2)
	);

	aluDecode decode (.opCode(aluOpCode), .aluOp(aluOp), .aluCarryUse(aluCarryUse));

	alu aluUnit (
		.op1(op1), .op2(op2), .aluOp(aluOp), .carryUse(aluCarryUse),
		.carryIn(aluCarryIn), .result(aluRes), .flags(flags)
	);

	trisreg pcReg (
		.Clock(Clock), .rstN(rstN), .regEn(pcEn), .regWe(pcWe),
		.dataIn(pcIn), .dataOut(pc), .trisOut(sysBus)
	);
	trisreg lrReg (
		.Clock(Clock), .rstN(rstN), .regEn(lrEn), .regWe(lrWe),
		.dataIn(lrIn), .dataOut(lr), .trisOut(sysBus)
	);
	trisreg irReg ( // listens only and never drives
		.Clock(Clock), .rstN(rstN), .regEn(1'b0), .regWe(irWe),
		.dataIn(sysBus), .dataOut(ir), .trisOut(sysBus)
	);
	trisreg aluOutReg (
		.Clock(Clock), .rstN(rstN), .regEn(aluEn), .regWe(aluWe),
		.dataIn(aluRes), .dataOut(), .trisOut(sysBus)
	);

endmodule

// ==== design/alu.sv ====
// combinational ALU; moves OR the operands so the unused one must be zero, shifts are by one bit
`timescale 1ns/1ps
module alu import opcodes::*; (
	input logic [wordW-1:0] op1,
	input logic [wordW-1:0] op2,
	input aluFunctionT aluOp,
	input logic carryUse,
	input logic carryIn,
	output logic [wordW-1:0] result,
	output logic [3:0] flags
);

	logic [wordW:0] sum;      // carry out in the top bit
	logic [wordW-1:0] op2Eff; // op2 as seen by the adder
	logic carryBit;
	logic arith;

	always_comb begin
		op2Eff = op2;
		carryBit = carryUse & carryIn;
		arith = 1'b0;
		result = '0;
		case (aluOp)
			fnAdd: arith = 1'b1;
			fnSub: begin
				op2Eff = ~op2;
				carryBit = carryUse ? carryIn : 1'b1; // plain subtract adds one
				arith = 1'b1;
			end
			fnAnd: result = op1 & op2;
			fnOr: result = op1 | op2;
			fnXor: result = op1 ^ op2;
			fnNot: result = ~op1;
			fnLsl: result = {op1[wordW-2:0], 1'b0};
			fnLsr: result = {1'b0, op1[wordW-1:1]};
			fnAsr: result = {op1[wordW-1], op1[wordW-1:1]}; // keep sign
			default: result = op1 | op2; // fnPass
		endcase

		// one shared adder for add and subtract
		sum = {1'b0, op1} + {1'b0, op2Eff} + {{wordW{1'b0}}, carryBit};
		if (arith) begin
			result = sum[wordW-1:0];
		end

		flags[flagN] = result[wordW-1];
		flags[flagZ] = (result == '0);
		flags[flagC] = arith & sum[wordW];
		// overflow when both adder inputs agree in sign and the result does not
		flags[flagV] = arith & (op1[wordW-1] == op2Eff[wordW-1])
			& (result[wordW-1] != op1[wordW-1]);
	end

endmodule

// ==== design/aluDecode.sv ====
// opcode to ALU function; branch and unknown codes fall back to fnPass
`timescale 1ns/1ps
module aluDecode import opcodes::*; (
	input opcodeT opCode,
	output aluFunctionT aluOp,
	output logic aluCarryUse
);

	always_comb begin
		aluCarryUse = 1'b0;
		case (opCode)
			ADD, ADDI: aluOp = fnAdd;
			ADC, ADCI: begin
				aluOp = fnAdd;
				aluCarryUse = 1'b1; // take carry-in
			end
			SUB, SUBI: aluOp = fnSub;
			SUC, SUCI: begin
				aluOp = fnSub;
				aluCarryUse = 1'b1; // carry replaces the +1
			end
			AND: aluOp = fnAnd;
			OR: aluOp = fnOr;
			XOR: aluOp = fnXor;
			NOT: aluOp = fnNot;
			LSL: aluOp = fnLsl;
			LSR: aluOp = fnLsr;
			ASR: aluOp = fnAsr;
			MOV, MOVI: aluOp = fnPass;
			default: aluOp = fnPass;
		endcase
	end

endmodule

// ==== design/regBlock.sv ====
// eight general registers, r7 doubles as link; a read of the register being written sees the old value
`timescale 1ns/1ps
module regBlock import opcodes::*; (
	input logic Clock,
	input logic rstN,
	input logic we,
	input logic [2:0] rs1,
	input logic [2:0] rs2,
	input logic [2:0] rw,
	input logic [wordW-1:0] wData,
	output logic [wordW-1:0] rd1,
	output logic [wordW-1:0] rd2
);

	logic [wordW-1:0] regs [8];

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rw] <= wData; // single write port
		end
	end

	// both read ports are plain muxes
	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

endmodule

// ==== design/trisreg.sv ====
// bus register; the controller must keep every other bus driver off while regEn is high
`timescale 1ns/1ps
module trisreg import opcodes::*; (
	input logic Clock,
	input logic rstN,
	input logic regEn,
	input logic regWe,
	input logic [wordW-1:0] dataIn,
	output logic [wordW-1:0] dataOut,
	inout wire [wordW-1:0] trisOut
);

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			dataOut <= '0;
		end else if (regWe) begin
			dataOut <= dataIn; // load on strobe only
		end
	end

	// release the bus when not selected
	assign trisOut = regEn ? dataOut : {wordW{1'bz}};

endmodule

// ==== design/opcodes.sv ====
// shared encodings for the 16-bit datapath; opcode and select values must match the controller
package opcodes;

	localparam int wordW = 16;
	localparam logic [15:0] intVector = 16'h0010; // interrupt entry PC

	// bit positions inside the 4-bit flag word
	localparam int flagN = 3;
	localparam int flagZ = 2;
	localparam int flagC = 1;
	localparam int flagV = 0;

	typedef enum logic [4:0] {
		ADD  = 5'b00000,
		ADDI = 5'b00001,
		ADC  = 5'b00010,
		ADCI = 5'b00011,
		SUB  = 5'b00100,
		SUBI = 5'b00101,
		SUC  = 5'b00110,
		SUCI = 5'b00111,
		AND  = 5'b01000,
		OR   = 5'b01001,
		XOR  = 5'b01010,
		NOT  = 5'b01011,
		LSL  = 5'b01100,
		LSR  = 5'b01101,
		ASR  = 5'b01110,
		MOV  = 5'b01111,
		MOVI = 5'b10000,
		BR   = 5'b11000, // branches only matter to the controller
		BNE  = 5'b11001,
		BE   = 5'b11010,
		BLT  = 5'b11011,
		BGE  = 5'b11100,
		BWL  = 5'b11101,
		RET  = 5'b11110
	} opcodeT;

	typedef enum logic [3:0] {
		fnAdd,
		fnSub,
		fnAnd,
		fnOr,
		fnXor,
		fnNot,
		fnLsl,
		fnLsr,
		fnAsr,
		fnPass
	} aluFunctionT;

	typedef struct packed {
		opcodeT opcode;
		logic [2:0] rd;
		logic [2:0] ra;
		logic [2:0] rb;
		logic [1:0] pad;
	} regFormT;

	// short immediate is imm[4:0]
	typedef struct packed {
		opcodeT opcode;
		logic [2:0] rd;
		logic [7:0] imm;
	} immFormT;

	typedef union packed {
		regFormT regForm;
		immFormT immForm;
	} instrWordT;

	typedef enum logic { immShort, immLong } immSelT;
	typedef enum logic { op1Rd1, op1Pc } op1SelT;
	typedef enum logic [1:0] { op2Rd2, op2Imm, op2Zero } op2SelT;
	typedef enum logic [1:0] { rwSeven, rwRd, rwRa } rwSelT;
	typedef enum logic { rs1Rd, rs1Ra } rs1SelT;
	typedef enum logic [2:0] { pcLr, pcAluOut, pcSysBus, pcInc, pcInt } pcSelT;
	typedef enum logic { lrPc, lrSys } lrSelT;
	typedef enum logic { wdAlu, wdSys } wdSelT;
	typedef enum logic [1:0] { orNone, orAdd, orSub } aluOrSelT;

endpackage
